/* build.f */
hdl/clk_div_pkg.sv
hdl/div_ctrl_if.sv
hdl/clk_even_div_static.sv
hdl/clk_odd_div_static.sv
hdl/div_cfg_reg.sv
hdl/clk_int_div_simple.sv
hdl/clk_div_top.sv
verification/tb_clk_div_top.sv

/* Bender.yml */
package:
  name: clk_div

sources:
  - hdl/clk_div_pkg.sv
  - hdl/div_ctrl_if.sv
  - hdl/clk_even_div_static.sv
  - hdl/clk_odd_div_static.sv
  - hdl/div_cfg_reg.sv
  - hdl/clk_int_div_simple.sv
  - hdl/clk_div_top.sv
  - target: test
    files:
      - verification/tb_clk_div_top.sv

/* verification/tb_clk_div_top.sv */
//////////////////////////////
// Clock divider testbench
// Random ratio loads checked against edge-counting
// models of the even, odd and programmable dividers
//////////////////////////////

`timescale 1ns/10ps

module tb_clk_div_top;

  localparam int CLK_PERIOD   = 10;
  localparam int RESET_CYCLES = 16;
  localparam int NUM_LOADS    = 8;
  // Triggers needed after a load before done rises
  localparam int SETTLE_TRG   = 2 ** clk_div_pkg::DONE_DELAY_WIDTH - 1;
  // Eight loads at the widest ratio for eight trigger periods each plus a margin
  localparam int WATCHDOG_CYCLES = NUM_LOADS * 8 * 256 + 8192;

  logic                              clk_i;
  logic                              arst_n_i;
  logic [clk_div_pkg::DIV_WIDTH-1:0] div_value_i;
  logic                              div_load_i;
  logic                              clk_even_o;
  logic                              clk_odd_o;
  logic                              clk_trg_o;
  logic                              div_done_o;

  // Rising edges of clk_i counted from reset release
  int cyc = 0;
  int errors = 0;
  int err_start = 0;
  int pass_cnt = 0;
  int fail_cnt = 0;

  clk_div_top clk_div_top_i (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .div_value_i (div_value_i),
    .div_load_i  (div_load_i),
    .clk_even_o  (clk_even_o),
    .clk_odd_o   (clk_odd_o),
    .clk_trg_o   (clk_trg_o),
    .div_done_o  (div_done_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  // The release edge itself still sees reset low, so edge 1 is the first counted
  always @(posedge clk_i) begin
    if (arst_n_i) begin
      cyc <= cyc + 1;
    end
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Timeout: the run did not finish within %0d clock cycles", WATCHDOG_CYCLES);
    $display("*** TEST FAILED ***");
    $finish;
  end

  // Even output flips every EVEN_DIV/2 edges and starts low
  function automatic logic even_level(input int n);
    return ((n / (clk_div_pkg::EVEN_DIV / 2)) % 2) == 1;
  endfunction

  // Odd output is counted in half cycles with two per input cycle
  // It rises at edge (ODD_DIV-1)/2 and stays high for ODD_DIV half cycles
  function automatic logic odd_level(input int t);
    int first_rise;
    first_rise = clk_div_pkg::ODD_DIV - 1;
    if (t < first_rise) begin
      return 1'b0;
    end
    return ((t - first_rise) % (2 * clk_div_pkg::ODD_DIV)) < clk_div_pkg::ODD_DIV;
  endfunction

  task automatic check_level(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("Mismatch in %s at %0t: expected %0b, actual %0b", name, $time, exp, act);
      errors++;
    end
  endtask

  task automatic finish_test(input string name);
    if (errors == err_start) begin
      pass_cnt++;
      $display("Test %s passed", name);
    end else begin
      fail_cnt++;
      $display("Test %s failed with %0d errors", name, errors - err_start);
    end
    err_start = errors;
  endtask

  // Returns right after the edge that samples the load
  task automatic issue_load(input logic [clk_div_pkg::DIV_WIDTH-1:0] v);
    @(posedge clk_i);
    div_value_i <= v;
    div_load_i  <= 1'b1;
    @(posedge clk_i);
    div_load_i  <= 1'b0;
  endtask

  // Edge m counts from the load-sampling edge and the counter clears at edge 1
  // A trigger showing after edge m is latched at edge m+1, so the first is at v+2
  task automatic run_ratio_check(input int v, input int n_cyc, input string name);
    logic exp_trg;
    logic exp_done;
    // The strobe cycle right after the sampling edge never carries a trigger
    #2;
    check_level({name, " trg"}, 1'b0, clk_trg_o);
    for (int m = 1; m <= n_cyc; m++) begin
      @(posedge clk_i);
      #2;
      exp_trg  = (m % (v + 1)) == 0;
      // Each trigger enters the settle count one edge after it shows
      exp_done = ((m - 1) / (v + 1)) >= SETTLE_TRG;
      check_level({name, " trg"}, exp_trg, clk_trg_o);
      check_level({name, " done"}, exp_done, div_done_o);
    end
  endtask

  initial begin
    int load_vals [NUM_LOADS];
    int v1;
    int v2;
    string tname;
    void'($urandom(89));
    arst_n_i    = 1'b0;
    div_value_i = '0;
    div_load_i  = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_i);
    arst_n_i <= 1'b1;
    #2;
    // Everything idles low out of reset and the default ratio runs at once
    check_level("reset even", 1'b0, clk_even_o);
    check_level("reset odd", 1'b0, clk_odd_o);
    check_level("reset done", 1'b0, div_done_o);
    check_level("reset trg", 1'b0, clk_trg_o);
    for (int n = 1; n <= int'(clk_div_pkg::DIV_RESET) + 1; n++) begin
      @(posedge clk_i);
      #2;
      check_level("reset trg", n == int'(clk_div_pkg::DIV_RESET), clk_trg_o);
    end
    finish_test("reset");
    repeat (40) begin
      @(posedge clk_i);
      #2;
      check_level("even_div", even_level(cyc), clk_even_o);
    end
    finish_test("even_div");
    // Odd output is checked after both clock edges to see the half cycle
    repeat (40) begin
      @(posedge clk_i);
      #2;
      check_level("odd_div rise", odd_level(2 * cyc), clk_odd_o);
      @(negedge clk_i);
      #2;
      check_level("odd_div fall", odd_level(2 * cyc + 1), clk_odd_o);
    end
    finish_test("odd_div");
    load_vals[0] = 0;
    load_vals[1] = 255;
    // After the 255 run the old count sits at two in the strobe cycle of this load
    load_vals[2] = 2;
    for (int i = 3; i < NUM_LOADS; i++) begin
      load_vals[i] = $urandom % 256;
    end
    // Each run goes one trigger period past the done rise
    for (int i = 0; i < NUM_LOADS; i++) begin
      tname = $sformatf("load_%0d", load_vals[i]);
      issue_load(load_vals[i]);
      run_ratio_check(load_vals[i], 8 * (load_vals[i] + 1) + 1, tname);
      finish_test(tname);
    end
    // Second load lands after three triggers and well before done rises
    v1 = $urandom % 256;
    v2 = $urandom % 256;
    issue_load(v1);
    run_ratio_check(v1, 3 * (v1 + 1), "reload first");
    issue_load(v2);
    run_ratio_check(v2, 8 * (v2 + 1) + 1, "reload second");
    finish_test("reload_before_done");
    $display("Summary: %0d tests passed, %0d tests failed", pass_cnt, fail_cnt);
    if (fail_cnt == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

/* hdl/clk_div_top.sv */
//////////////////////////////
// Clock division top level
// Fixed even and odd dividers plus the programmable
// trigger generator with its config register
//////////////////////////////

`timescale 1ns/10ps

module clk_div_top (
  input  logic                              clk_i,
  input  logic                              arst_n_i,
  input  logic [clk_div_pkg::DIV_WIDTH-1:0] div_value_i,
  input  logic                              div_load_i,
  output logic                              clk_even_o,
  output logic                              clk_odd_o,
  output logic                              clk_trg_o,
  output logic                              div_done_o
);

  // Control bundle between the config register and the divider
  div_ctrl_if u_div_ctrl ();

  // Fixed even ratio output
  clk_even_div_static #(
    .DIV_VALUE (clk_div_pkg::EVEN_DIV)
  ) u_even_div (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .clk_o    (clk_even_o)
  );

  // Fixed odd ratio output with 50 % duty
  clk_odd_div_static #(
    .DIV_VALUE (clk_div_pkg::ODD_DIV)
  ) u_odd_div (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .clk_o    (clk_odd_o)
  );

  // Ratio register and load strobe
  div_cfg_reg u_cfg_reg (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .div_value_i (div_value_i),
    .div_load_i  (div_load_i),
    .ctrl        (u_div_ctrl.cfg),
    .clk_trg_o   (clk_trg_o),
    .div_done_o  (div_done_o)
  );

  // Programmable trigger generator
  clk_int_div_simple u_int_div (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .ctrl     (u_div_ctrl.gen)
  );

endmodule

/* hdl/clk_int_div_simple.sv */
//////////////////////////////
// Programmable trigger generator
// Issues a one-cycle trigger every div+1 cycles and
// raises done once the new ratio has produced a fixed
// number of triggers
//////////////////////////////

`timescale 1ns/10ps

module clk_int_div_simple (
  input  logic    clk_i,
  input  logic    arst_n_i,
  div_ctrl_if.gen ctrl
);

  localparam int                                   SETTLE_W   = clk_div_pkg::DONE_DELAY_WIDTH;
  localparam logic [SETTLE_W-1:0]                  SETTLE_MAX = '1;

  logic [clk_div_pkg::DIV_WIDTH-1:0] cnt_q;
  logic [SETTLE_W-1:0]               settle_q;
  logic                              cnt_match;
  logic                              trg;
  logic                              settled;

  // Counter has reached the programmed ratio
  assign cnt_match = (cnt_q == ctrl.div);

  // No trigger in the strobe cycle, the old count means nothing
  // against the freshly loaded ratio
  assign trg = cnt_match & ~ctrl.div_valid;

  assign settled = (settle_q == SETTLE_MAX);

  // Period counter, restarted by a load and wrapping at div
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cnt_q <= '0;
    end else if (ctrl.div_valid || cnt_match) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  // Settle counter, counts triggers since the last load
  // and stops once it is all ones
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      settle_q <= '0;
    end else if (ctrl.div_valid) begin
      settle_q <= '0;
    end else if (trg && !settled) begin
      settle_q <= settle_q + 1'b1;
    end
  end

  assign ctrl.clk_trg  = trg;
  assign ctrl.div_done = settled;

endmodule

/* hdl/div_cfg_reg.sv */
//////////////////////////////
// Divider config register
// Holds the programmable ratio in flops and turns a
// top-level load into a one-cycle valid strobe
//////////////////////////////

`timescale 1ns/10ps

module div_cfg_reg (
  input  logic                              clk_i,
  input  logic                              arst_n_i,
  input  logic [clk_div_pkg::DIV_WIDTH-1:0] div_value_i,
  input  logic                              div_load_i,
  div_ctrl_if.cfg                           ctrl,
  output logic                              clk_trg_o,
  output logic                              div_done_o
);

  logic [clk_div_pkg::DIV_WIDTH-1:0] div_q;
  logic                              div_valid_q;

  // The divider compares against this register every cycle, so the
  // ratio must come from a flop and never from the input pins directly
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      div_q <= clk_div_pkg::DIV_RESET;
    end else if (div_load_i) begin
      div_q <= div_value_i;
    end
  end

  // Strobe is high for exactly the cycle after the load was sampled
  // A load during the strobe cycle just restarts the sequence
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      div_valid_q <= 1'b0;
    end else begin
      div_valid_q <= div_load_i;
    end
  end

  assign ctrl.div       = div_q;
  assign ctrl.div_valid = div_valid_q;

  // Divider status goes straight out to the top-level pins
  assign clk_trg_o  = ctrl.clk_trg;
  assign div_done_o = ctrl.div_done;

endmodule

/* hdl/clk_odd_div_static.sv */
//////////////////////////////
// Odd static clock divider
// Divides clk_i by a fixed odd ratio with a 50 % duty
// cycle by combining a rising-edge and a falling-edge
// toggle flop through an XOR
//////////////////////////////

`timescale 1ns/10ps

module clk_odd_div_static #(
  parameter int DIV_VALUE = 3
) (
  input  logic clk_i,
  input  logic arst_n_i,
  output logic clk_o
);

  localparam int CNT_WIDTH = $clog2(DIV_VALUE) + 1;

  logic [CNT_WIDTH-1:0] cnt_q;
  logic                 cnt_wrap;
  logic                 mid_hit;
  logic                 clk_pos_q;
  logic                 clk_neg_q;

  // Full period boundary of the counter
  assign cnt_wrap = (cnt_q == CNT_WIDTH'(DIV_VALUE - 1));

  // Point inside the period where the rising-edge flop flips
  assign mid_hit = (cnt_q == CNT_WIDTH'((DIV_VALUE - 1) / 2 - 1));

  // Period counter, runs 0 .. DIV_VALUE-1
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cnt_q <= '0;
    end else if (cnt_wrap) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  // Rising-edge toggle, flips once per period
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      clk_pos_q <= 1'b0;
    end else if (mid_hit) begin
      clk_pos_q <= ~clk_pos_q;
    end
  end

  // Falling-edge toggle, also flips once per period
  // Sampling on the falling edge shifts it by half an input cycle,
  // which supplies the extra half cycle an odd ratio needs
  always_ff @(negedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      clk_neg_q <= 1'b0;
    end else if (cnt_wrap) begin
      clk_neg_q <= ~clk_neg_q;
    end
  end

  // Each flop has a period of 2*DIV_VALUE, their XOR has DIV_VALUE
  // with a high time of DIV_VALUE/2 input cycles
  assign clk_o = clk_pos_q ^ clk_neg_q;

endmodule

/* hdl/clk_even_div_static.sv */
//////////////////////////////
// Even static clock divider
// Divides clk_i by a fixed even ratio using a
// half-period counter and a toggle flop
//////////////////////////////

`timescale 1ns/10ps

module clk_even_div_static #(
  parameter int DIV_VALUE = 2
) (
  input  logic clk_i,
  input  logic arst_n_i,
  output logic clk_o
);

  // One spare bit keeps the compare safe for small ratios
  localparam int CNT_WIDTH = $clog2(DIV_VALUE) + 1;

  logic [CNT_WIDTH-1:0] cnt_q;
  logic                 half_wrap;
  logic                 clk_q;

  // End of a half period, the output flips here
  assign half_wrap = (cnt_q == CNT_WIDTH'(DIV_VALUE / 2 - 1));

  // Half-period counter, wraps every DIV_VALUE/2 input cycles
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cnt_q <= '0;
    end else if (half_wrap) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  // Toggle flop, starts low out of reset
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      clk_q <= 1'b0;
    end else if (half_wrap) begin
      clk_q <= ~clk_q;
    end
  end

  assign clk_o = clk_q;

endmodule

/* hdl/div_ctrl_if.sv */
//////////////////////////////
// Divider control interface
// Carries the ratio, its load strobe and the trigger and
// done status between the config register and the
// programmable divider
//////////////////////////////

`timescale 1ns/10ps

interface div_ctrl_if;

  // Ratio field, only changes together with a div_valid strobe
  logic [clk_div_pkg::DIV_WIDTH-1:0] div;
  // One-cycle load strobe, always accepted
  logic                              div_valid;
  // One-cycle trigger pulse from the divider
  logic                              clk_trg;
  // Level that marks a settled ratio
  logic                              div_done;

  // Config side drives the ratio and sees the divider status
  modport cfg (
    output div,
    output div_valid,
    input  clk_trg,
    input  div_done
  );

  // Divider side consumes the ratio and reports its status
  modport gen (
    input  div,
    input  div_valid,
    output clk_trg,
    output div_done
  );

endinterface

/* hdl/clk_div_pkg.sv */
//////////////////////////////
// Clock divider package
// Shared widths, fixed division ratios and the reset ratio
// used by the clock division subsystem
//////////////////////////////

package clk_div_pkg;

  // Width of the programmable ratio field
  // The divide factor is the field value plus one
  localparam int DIV_WIDTH = 8;

  // Width of the settle counter that counts triggers after a load
  // Done rises once it saturates at all ones
  localparam int DONE_DELAY_WIDTH = 3;

  // Ratio of the fixed even divider, must be even
  localparam int EVEN_DIV = 4;

  // Ratio of the fixed odd divider, must be odd
  localparam int ODD_DIV = 5;

  // Ratio field value held after reset (divide by four)
  localparam logic [DIV_WIDTH-1:0] DIV_RESET = 8'd3;

endpackage
